/* logic/load_pkg.sv */
package load_pkg;

    // Word with a per-byte view
    typedef union packed {
        logic [31:0]      word;
        logic [3:0][7:0]  bytes;
    } DATA;

    typedef logic [3:0] BYTE_MASK;   // One bit per byte lane

    // Address with a view into the 64-bit cache line
    typedef union packed {
        logic [31:0] addr;
        struct packed {
            logic [28:0] line;
            logic        w_idx;      // Word select within the line
            logic [1:0]  b_idx;      // Byte offset within the word
        } dw;
    } ADDR;

    typedef logic [3:0] BR_MASK;     // One bit per unresolved branch
    typedef logic [1:0] MSHR_IDX;
    typedef logic [2:0] SQ_IDX;
    typedef logic [5:0] PREG_IDX;

    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU
    } load_func_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] base;
        logic [31:0] offset;
        load_func_e  load_func;
        PREG_IDX     dest_reg_idx;
        BR_MASK      bm;
        SQ_IDX       sq_tail;
    } LOAD_ISSUE_PACKET;

    typedef struct packed {
        logic        valid;
        ADDR         load_addr;
        load_func_e  load_func;
        BYTE_MASK    byte_mask;      // Bytes the load reads
        PREG_IDX     dest_reg_idx;
        BR_MASK      bm;
        SQ_IDX       sq_tail;
    } LOAD_DATA_PACKET;

    typedef struct packed {
        logic        valid;
        ADDR         load_addr;
        load_func_e  load_func;
        BYTE_MASK    byte_mask;      // Bytes still missing
        PREG_IDX     dest_reg_idx;
        BR_MASK      bm;
        SQ_IDX       sq_tail;
        DATA         result;
        MSHR_IDX     mshr_idx;
    } LOAD_BUFFER_PACKET;

    typedef struct packed {
        logic        valid;
        PREG_IDX     dest_reg_idx;
        DATA         result;
    } WB_PACKET;

    localparam LOAD_DATA_PACKET   NOP_LOAD_DATA_PACKET   = '0;
    localparam LOAD_BUFFER_PACKET NOP_LOAD_BUFFER_PACKET = '0;

    // True when a mispredicted branch covers this load
    function automatic logic squashed(BR_MASK bm, BR_MASK resolve, logic mispred);
        return mispred && (|(bm & resolve));
    endfunction

endpackage

/* logic/load_addr_stage.sv */
module load_addr_stage (
    input  logic                       clock,
    input  logic                       reset,
    input  load_pkg::LOAD_ISSUE_PACKET load_issue,
    input  logic                       load_data_free,
    input  load_pkg::BR_MASK           br_resolve,
    input  logic                       br_mispred,
    output logic                       issue_free,
    output load_pkg::LOAD_DATA_PACKET  load_data_packet
);
    import load_pkg::*;

    LOAD_DATA_PACKET held;      // Load waiting for the data stage
    LOAD_DATA_PACKET issued;    // Incoming load after address calculation
    ADDR             issue_addr;

    assign issue_free = !held.valid || load_data_free;

    always_comb begin
        issue_addr.addr = load_issue.base + load_issue.offset;
        issued.valid        = load_issue.valid;
        issued.load_addr    = issue_addr;
        issued.load_func    = load_issue.load_func;
        issued.dest_reg_idx = load_issue.dest_reg_idx;
        issued.sq_tail      = load_issue.sq_tail;
        issued.bm           = load_issue.bm & ~br_resolve;
        case (load_issue.load_func)
            LB, LBU: issued.byte_mask = 4'b0001 << issue_addr.dw.b_idx;
            LH, LHU: issued.byte_mask = 4'b0011 << {issue_addr.dw.b_idx[1], 1'b0};
            default: issued.byte_mask = 4'b1111;
        endcase
        if (squashed(load_issue.bm, br_resolve, br_mispred)) begin
            issued = NOP_LOAD_DATA_PACKET;
        end
    end

    // Held load as seen after this cycle's branch outcome
    always_comb begin
        load_data_packet    = held;
        load_data_packet.bm = held.bm & ~br_resolve;
        if (squashed(held.bm, br_resolve, br_mispred)) begin
            load_data_packet = NOP_LOAD_DATA_PACKET;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            held <= NOP_LOAD_DATA_PACKET;
        end else if (issue_free) begin
            held <= issued;
        end else begin
            held <= load_data_packet;   // Stalled, keep branch state current
        end
    end

    halfword_aligned: assert property (@(posedge clock) disable iff (reset)
        held.valid && (held.load_func inside {LH, LHU}) |-> !held.load_addr.dw.b_idx[0]);

endmodule

/* logic/load_data_stage.sv */
module load_data_stage (
    input  logic                        clock,
    input  logic                        reset,
    input  load_pkg::LOAD_DATA_PACKET   load_data_packet_in,
    input  logic                        cache_load_accepted,
    input  load_pkg::DATA      [1:0]    cache_load_data,
    input  load_pkg::BYTE_MASK [1:0]    cache_data_mask,
    input  load_pkg::MSHR_IDX           cache_mshr_idx,
    input  load_pkg::DATA               sq_load_data,
    input  load_pkg::BYTE_MASK          sq_data_mask,
    input  load_pkg::BR_MASK            br_resolve,
    input  logic                        br_mispred,
    output logic                        load_data_free,
    output logic                        load_valid,
    output load_pkg::SQ_IDX             load_sq_tail,
    output load_pkg::ADDR               load_addr,
    output load_pkg::LOAD_BUFFER_PACKET load_buffer_packet
);
    import load_pkg::*;

    LOAD_DATA_PACKET held;      // Load presented to cache and store queue
    LOAD_DATA_PACKET held_upd;  // Same load after branch outcome
    logic            word_sel;

    // Stage moves on once the cache takes the request
    assign load_data_free = !held.valid || cache_load_accepted;
    assign load_valid     = held.valid;
    assign load_addr      = held.load_addr;
    assign load_sq_tail   = held.sq_tail;
    assign word_sel       = held.load_addr.dw.w_idx;

    always_comb begin
        held_upd    = held;
        held_upd.bm = held.bm & ~br_resolve;
        if (squashed(held.bm, br_resolve, br_mispred)) begin
            held_upd = NOP_LOAD_DATA_PACKET;
        end
    end

    always_comb begin
        load_buffer_packet.valid        = held_upd.valid;
        load_buffer_packet.load_addr    = held_upd.load_addr;
        load_buffer_packet.load_func    = held_upd.load_func;
        load_buffer_packet.dest_reg_idx = held_upd.dest_reg_idx;
        load_buffer_packet.bm           = held_upd.bm;
        load_buffer_packet.sq_tail      = held_upd.sq_tail;
        load_buffer_packet.mshr_idx     = cache_mshr_idx;
        load_buffer_packet.result       = '0;
        load_buffer_packet.byte_mask    = held_upd.byte_mask;
        for (int i = 0; i < 4; i++) begin
            if (held_upd.byte_mask[i]) begin
                if (sq_data_mask[i]) begin                   // Younger store wins
                    load_buffer_packet.result.bytes[i] = sq_load_data.bytes[i];
                    load_buffer_packet.byte_mask[i]    = 1'b0;
                end else if (cache_data_mask[word_sel][i]) begin
                    load_buffer_packet.result.bytes[i] = cache_load_data[word_sel].bytes[i];
                    load_buffer_packet.byte_mask[i]    = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            held <= NOP_LOAD_DATA_PACKET;
        end else if (load_data_free) begin
            held <= load_data_packet_in;
        end else begin
            held <= held_upd;
        end
    end

    // The cache answers only a request that is on the bus
    accept_needs_request: assert property (@(posedge clock) disable iff (reset)
        cache_load_accepted |-> load_valid);

endmodule

/* logic/load_buffer.sv */
module load_buffer #(
    parameter int LB_DEPTH = 4
) (
    input  logic                                       clock,
    input  logic                                       reset,
    input  load_pkg::LOAD_BUFFER_PACKET                load_buffer_packet,
    input  logic                                       cache_load_accepted,
    input  logic                                       fill_valid,
    input  load_pkg::MSHR_IDX                          fill_mshr_idx,
    input  load_pkg::DATA [1:0]                        fill_data,
    input  load_pkg::BR_MASK                           br_resolve,
    input  logic                                       br_mispred,
    input  logic [LB_DEPTH-1:0]                        wb_release,
    output load_pkg::LOAD_BUFFER_PACKET [LB_DEPTH-1:0] entries,
    output logic [LB_DEPTH-1:0]                        ready,
    output logic                                       load_buffer_full
);
    import load_pkg::*;

    logic [LB_DEPTH-1:0] valid_vec;
    logic [LB_DEPTH-1:0] kill;          // Entry squashed this cycle
    logic [LB_DEPTH-1:0] fill_hit;      // Entry completed by this fill
    logic [LB_DEPTH-1:0] free_slot;     // One-hot lowest empty entry
    DATA  [LB_DEPTH-1:0] filled;
    logic                write_en;

    assign write_en         = cache_load_accepted && load_buffer_packet.valid;
    assign load_buffer_full = &valid_vec;
    assign free_slot        = ~valid_vec & (valid_vec + 1'b1);

    always_comb begin
        for (int i = 0; i < LB_DEPTH; i++) begin
            valid_vec[i] = entries[i].valid;
            kill[i]      = squashed(entries[i].bm, br_resolve, br_mispred);
            // A load killed now must not reach writeback
            ready[i]     = entries[i].valid && (entries[i].byte_mask == '0) && !kill[i];
            fill_hit[i]  = fill_valid && entries[i].valid
                           && (entries[i].mshr_idx == fill_mshr_idx)
                           && (|entries[i].byte_mask);
            filled[i]    = entries[i].result;
            for (int b = 0; b < 4; b++) begin
                if (entries[i].byte_mask[b]) begin
                    filled[i].bytes[b] = fill_data[entries[i].load_addr.dw.w_idx].bytes[b];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < LB_DEPTH; i++) begin
                entries[i] <= NOP_LOAD_BUFFER_PACKET;
            end
        end else begin
            for (int i = 0; i < LB_DEPTH; i++) begin
                if (write_en && free_slot[i]) begin
                    entries[i] <= load_buffer_packet;
                end else if (kill[i] || wb_release[i]) begin
                    entries[i] <= NOP_LOAD_BUFFER_PACKET;
                end else if (entries[i].valid) begin
                    entries[i].bm <= entries[i].bm & ~br_resolve;
                    if (fill_hit[i]) begin
                        entries[i].result    <= filled[i];   // Only missing lanes change
                        entries[i].byte_mask <= '0;
                    end
                end
            end
        end
    end

    // Cache holds accepts while there is no room
    no_write_when_full: assert property (@(posedge clock) disable iff (reset)
        load_buffer_full |-> !cache_load_accepted);

endmodule

/* logic/load_writeback.sv */
module load_writeback #(
    parameter int LB_DEPTH = 4
) (
    input  logic                                       clock,
    input  logic                                       reset,
    input  load_pkg::LOAD_BUFFER_PACKET [LB_DEPTH-1:0] entries,
    input  logic [LB_DEPTH-1:0]                        ready,
    output logic [LB_DEPTH-1:0]                        wb_release,
    output load_pkg::WB_PACKET                         wb
);
    import load_pkg::*;

    logic [$clog2(LB_DEPTH)-1:0] sel;
    logic [31:0]                 shifted;   // Requested bytes moved to lane 0
    DATA                         extended;

    // Lowest ready index wins
    always_comb begin
        sel        = '0;
        wb_release = '0;
        for (int i = LB_DEPTH - 1; i >= 0; i--) begin
            if (ready[i]) begin
                sel = $bits(sel)'(i);
            end
        end
        if (|ready) begin
            wb_release[sel] = 1'b1;
        end
    end

    always_comb begin
        shifted = entries[sel].result.word >> {entries[sel].load_addr.dw.b_idx, 3'b000};
        case (entries[sel].load_func)
            LB:      extended.word = {{24{shifted[7]}}, shifted[7:0]};
            LBU:     extended.word = {24'b0, shifted[7:0]};
            LH:      extended.word = {{16{shifted[15]}}, shifted[15:0]};
            LHU:     extended.word = {16'b0, shifted[15:0]};
            default: extended.word = shifted;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb.valid        <= |ready;
            wb.dest_reg_idx <= entries[sel].dest_reg_idx;
            wb.result       <= extended;
        end
    end

endmodule

/* logic/load_unit.sv */
module load_unit #(
    parameter int LB_DEPTH = 4
) (
    input  logic                       clock,
    input  logic                       reset,
    input  load_pkg::LOAD_ISSUE_PACKET load_issue,
    input  logic                       cache_load_accepted,
    input  load_pkg::DATA      [1:0]   cache_load_data,
    input  load_pkg::BYTE_MASK [1:0]   cache_data_mask,
    input  load_pkg::MSHR_IDX          cache_mshr_idx,
    input  logic                       fill_valid,
    input  load_pkg::MSHR_IDX          fill_mshr_idx,
    input  load_pkg::DATA      [1:0]   fill_data,
    input  load_pkg::DATA              sq_load_data,
    input  load_pkg::BYTE_MASK         sq_data_mask,
    input  load_pkg::BR_MASK           br_resolve,
    input  logic                       br_mispred,
    output logic                       issue_free,
    output logic                       load_valid,
    output load_pkg::ADDR              load_addr,      // To cache and store queue
    output load_pkg::SQ_IDX            load_sq_tail,
    output logic                       load_buffer_full,
    output load_pkg::WB_PACKET         wb
);
    import load_pkg::*;

    logic                                load_data_free;
    LOAD_DATA_PACKET                     load_data_packet;
    LOAD_BUFFER_PACKET                   load_buffer_packet;
    LOAD_BUFFER_PACKET [LB_DEPTH-1:0]    entries;
    logic              [LB_DEPTH-1:0]    ready;
    logic              [LB_DEPTH-1:0]    wb_release;

    load_addr_stage u_addr (
        .clock            (clock),
        .reset            (reset),
        .load_issue       (load_issue),
        .load_data_free   (load_data_free),
        .br_resolve       (br_resolve),
        .br_mispred       (br_mispred),
        .issue_free       (issue_free),
        .load_data_packet (load_data_packet)
    );

    load_data_stage u_data (
        .clock               (clock),
        .reset               (reset),
        .load_data_packet_in (load_data_packet),
        .cache_load_accepted (cache_load_accepted),
        .cache_load_data     (cache_load_data),
        .cache_data_mask     (cache_data_mask),
        .cache_mshr_idx      (cache_mshr_idx),
        .sq_load_data        (sq_load_data),
        .sq_data_mask        (sq_data_mask),
        .br_resolve          (br_resolve),
        .br_mispred          (br_mispred),
        .load_data_free      (load_data_free),
        .load_valid          (load_valid),
        .load_sq_tail        (load_sq_tail),
        .load_addr           (load_addr),
        .load_buffer_packet  (load_buffer_packet)
    );

    load_buffer #(.LB_DEPTH(LB_DEPTH)) u_buffer (
        .clock               (clock),
        .reset               (reset),
        .load_buffer_packet  (load_buffer_packet),
        .cache_load_accepted (cache_load_accepted),
        .fill_valid          (fill_valid),
        .fill_mshr_idx       (fill_mshr_idx),
        .fill_data           (fill_data),
        .br_resolve          (br_resolve),
        .br_mispred          (br_mispred),
        .wb_release          (wb_release),
        .entries             (entries),
        .ready               (ready),
        .load_buffer_full    (load_buffer_full)
    );

    load_writeback #(.LB_DEPTH(LB_DEPTH)) u_wb (
        .clock      (clock),
        .reset      (reset),
        .entries    (entries),
        .ready      (ready),
        .wb_release (wb_release),
        .wb         (wb)
    );

endmodule

/* tests/clock_gen.sv */
module clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

/* tests/load_unit_tb.sv */
module load_unit_tb;
    import load_pkg::*;

    localparam int MAX_CASES = 32;
    localparam int LB_DEPTH  = 4;

    logic              clock;
    logic              reset;
    LOAD_ISSUE_PACKET  load_issue          = '0;
    logic              cache_load_accepted = 1'b0;
    DATA      [1:0]    cache_load_data     = '0;
    BYTE_MASK [1:0]    cache_data_mask     = '0;
    MSHR_IDX           cache_mshr_idx      = '0;
    logic              fill_valid          = 1'b0;
    MSHR_IDX           fill_mshr_idx       = '0;
    DATA      [1:0]    fill_data           = '0;
    DATA               sq_load_data        = '0;
    BYTE_MASK          sq_data_mask        = '0;
    BR_MASK            br_resolve          = '0;
    logic              br_mispred          = 1'b0;
    logic              issue_free;
    logic              load_valid;
    ADDR               load_addr;
    SQ_IDX             load_sq_tail;
    logic              load_buffer_full;
    WB_PACKET          wb;

    // One entry per line of the case file
    logic [127:0] case_name     [MAX_CASES];
    logic [31:0]  case_base     [MAX_CASES];
    logic [31:0]  case_offset   [MAX_CASES];
    logic [2:0]   case_func     [MAX_CASES];
    logic [5:0]   case_tag      [MAX_CASES];
    logic [3:0]   case_bm       [MAX_CASES];
    logic         case_squash   [MAX_CASES];
    logic [3:0]   case_sq_mask  [MAX_CASES];
    logic [31:0]  case_sq_data  [MAX_CASES];
    logic [3:0]   case_hit_mask [MAX_CASES];
    logic [63:0]  case_line     [MAX_CASES];
    logic [63:0]  case_fill     [MAX_CASES];
    logic [31:0]  case_expect   [MAX_CASES];
    int           n_cases = 0;

    logic [63:0] pending = '0;          // Outstanding loads by destination tag
    int          expect_case [64];
    int          expect_count  = 0;
    int          done_count    = 0;
    int          cycle_count   = 0;
    int          timeout_limit = 100;
    int          seed          = 43427;

    logic [3:0]  mshr_busy = '0;        // Cache miss slots waiting to fill
    int          mshr_case [4];
    int          mshr_wait [4];
    logic        stall = 1'b0;

    clock_gen u_clock (
        .clock (clock),
        .reset (reset)
    );

    load_unit #(.LB_DEPTH(LB_DEPTH)) u_dut (
        .clock               (clock),
        .reset               (reset),
        .load_issue          (load_issue),
        .cache_load_accepted (cache_load_accepted),
        .cache_load_data     (cache_load_data),
        .cache_data_mask     (cache_data_mask),
        .cache_mshr_idx      (cache_mshr_idx),
        .fill_valid          (fill_valid),
        .fill_mshr_idx       (fill_mshr_idx),
        .fill_data           (fill_data),
        .sq_load_data        (sq_load_data),
        .sq_data_mask        (sq_data_mask),
        .br_resolve          (br_resolve),
        .br_mispred          (br_mispred),
        .issue_free          (issue_free),
        .load_valid          (load_valid),
        .load_addr           (load_addr),
        .load_sq_tail        (load_sq_tail),
        .load_buffer_full    (load_buffer_full),
        .wb                  (wb)
    );

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic compare_value(logic [127:0] name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %0s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    // Byte lanes a load reads, from its width and byte offset
    function automatic logic [3:0] lanes_read(logic [2:0] func, logic [1:0] offset);
        case (func)
            3'd0, 3'd3: return 4'b0001 << offset;
            3'd1, 3'd4: return 4'b0011 << offset;
            default:    return 4'b1111;
        endcase
    endfunction

    function automatic int find_case(logic [31:0] addr);
        int i;
        int found;
        found = -1;
        for (i = n_cases - 1; i >= 0; i--) begin
            if (case_base[i] + case_offset[i] == addr) found = i;
        end
        return found;
    endfunction

    task automatic read_cases();
        int           fd;
        int           got;
        logic [8*200-1:0] text;
        logic [127:0] name;
        logic [31:0]  base, offset, func, tag, bm, squash, sq_mask, sq_data, hit_mask, expected;
        logic [63:0]  line_data, fill_line;
        fd = $fopen("tests/load_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/load_cases.txt");
            abort_run();
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            text = '0;
            got  = $fgets(text, fd);
            got  = $sscanf(text, "%s %h %h %h %h %h %h %h %h %h %h %h %h", name, base, offset,
                           func, tag, bm, squash, sq_mask, sq_data, hit_mask, line_data,
                           fill_line, expected);
            if (got == 13) begin            // Comment and blank lines fall through
                case_name[n_cases]     = name;
                case_base[n_cases]     = base;
                case_offset[n_cases]   = offset;
                case_func[n_cases]     = func[2:0];
                case_tag[n_cases]      = tag[5:0];
                case_bm[n_cases]       = bm[3:0];
                case_squash[n_cases]   = squash[0];
                case_sq_mask[n_cases]  = sq_mask[3:0];
                case_sq_data[n_cases]  = sq_data;
                case_hit_mask[n_cases] = hit_mask[3:0];
                case_line[n_cases]     = line_data;
                case_fill[n_cases]     = fill_line;
                case_expect[n_cases]   = expected;
                n_cases++;
            end
        end
        $fclose(fd);
        if (n_cases == 0) begin
            $display("the case file holds no loads");
            abort_run();
        end
    endtask

    // Issue one load, then resolve its branches in the next cycle
    task automatic issue_load(int ci);
        load_issue.valid        <= 1'b1;
        load_issue.base         <= case_base[ci];
        load_issue.offset       <= case_offset[ci];
        load_issue.load_func    <= load_func_e'(case_func[ci]);
        load_issue.dest_reg_idx <= case_tag[ci];
        load_issue.bm           <= case_bm[ci];
        load_issue.sq_tail      <= 3'(ci);
        if (!case_squash[ci]) begin
            pending[case_tag[ci]]     = 1'b1;
            expect_case[case_tag[ci]] = ci;
            expect_count++;
        end
        @(posedge clock);
        while (!issue_free) @(posedge clock);
        load_issue <= '0;
        br_resolve <= case_bm[ci];
        br_mispred <= case_squash[ci];
        @(posedge clock);
        br_resolve <= '0;
        br_mispred <= 1'b0;
    endtask

    // Cache and store queue answer the request on the bus
    always @(load_valid or load_addr or stall or load_buffer_full) begin : respond
        int ci;
        ci                  = find_case(load_addr.addr);
        sq_data_mask        = '0;
        sq_load_data        = '0;
        cache_data_mask     = '0;
        cache_load_data     = '0;
        cache_load_accepted = 1'b0;
        if (load_valid && ci >= 0) begin
            sq_data_mask                          = case_sq_mask[ci];
            sq_load_data                          = case_sq_data[ci];
            cache_load_data                       = case_line[ci];
            cache_data_mask[load_addr.dw.w_idx]   = case_hit_mask[ci];
            cache_load_accepted                   = !stall && !load_buffer_full;
        end
    end

    // Miss tracking, delayed fills and random stalls
    always @(posedge clock) begin : cache_model
        int         ci;
        int         m;
        int         slot;
        logic       sent;
        logic       found;
        logic [3:0] missing;
        fill_valid <= 1'b0;
        if (!reset) begin
            ci = find_case(load_addr.addr);
            if (load_valid && ci < 0) begin
                $display("the cache saw address %h that no load was issued to", load_addr.addr);
                abort_run();
            end else if (load_valid) begin
                // Store queue sees the tail the load was issued with
                compare_value(case_name[ci], {29'b0, 3'(ci)}, {29'b0, load_sq_tail});
                if (cache_load_accepted) begin
                    missing = lanes_read(case_func[ci], load_addr.dw.b_idx)
                              & ~case_sq_mask[ci] & ~case_hit_mask[ci];
                    if (missing != 4'b0000) begin
                        mshr_busy[cache_mshr_idx] = 1'b1;
                        mshr_case[cache_mshr_idx] = ci;
                        mshr_wait[cache_mshr_idx] = 4 + ($random(seed) & 15);
                    end
                end
            end
            sent = 1'b0;
            for (m = 0; m < 4; m++) begin
                if (mshr_busy[m] && mshr_wait[m] > 0) begin
                    mshr_wait[m]--;
                end else if (mshr_busy[m] && !sent) begin
                    fill_valid    <= 1'b1;
                    fill_mshr_idx <= 2'(m);
                    fill_data     <= case_fill[mshr_case[m]];
                    mshr_busy[m]  = 1'b0;
                    sent          = 1'b1;
                end
            end
            found = 1'b0;
            for (m = 1; m <= 4; m++) begin
                slot = (int'(cache_mshr_idx) + m) % 4;
                if (!mshr_busy[slot] && !found) begin
                    cache_mshr_idx <= 2'(slot);   // Next free slot in rotation
                    found = 1'b1;
                end
            end
            stall <= (($random(seed) & 3) == 0);
        end
    end

    // Writeback checks and run limit
    always @(posedge clock) begin
        if (!reset) begin
            cycle_count++;
            if (cycle_count > timeout_limit) begin
                $display("timeout: %0d of %0d loads never completed", expect_count - done_count,
                         expect_count);
                abort_run();
            end
            if (wb.valid) begin
                if (!pending[wb.dest_reg_idx]) begin
                    $display("writeback for tag %0d that was not outstanding", wb.dest_reg_idx);
                    abort_run();
                end else begin
                    compare_value(case_name[expect_case[wb.dest_reg_idx]],
                                  case_expect[expect_case[wb.dest_reg_idx]], wb.result.word);
                    pending[wb.dest_reg_idx] = 1'b0;
                    done_count++;
                end
            end
        end
    end

    initial begin : run
        int i;
        read_cases();
        timeout_limit = 40 * n_cases + 100;
        @(posedge clock);
        while (reset) @(posedge clock);
        for (i = 0; i < n_cases; i++) begin
            issue_load(i);
        end
        while (done_count < expect_count) @(posedge clock);
        repeat (10) @(posedge clock);    // Catch late or squashed writebacks
        if (done_count == expect_count && pending == '0 && !load_valid) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("loads were still in flight at the end of the run");
            abort_run();
        end
    end

endmodule

/* vlog.f */
logic/load_pkg.sv
logic/load_addr_stage.sv
logic/load_data_stage.sv
logic/load_buffer.sv
logic/load_writeback.sv
logic/load_unit.sv
tests/clock_gen.sv
tests/load_unit_tb.sv

/* Bender.yml */
package:
  name: load_unit

sources:
  - files:
      - logic/load_pkg.sv
      - logic/load_addr_stage.sv
      - logic/load_data_stage.sv
      - logic/load_buffer.sv
      - logic/load_writeback.sv
      - logic/load_unit.sv
  - target: test
    files:
      - tests/clock_gen.sv
      - tests/load_unit_tb.sv

/* tests/load_cases.txt */
# name base offset func(0 LB 1 LH 2 LW 3 LBU 4 LHU) tag bm squash
#   sq_mask sq_data hit_mask cache_line fill_line expected (one load per line, hex)
fwd_lw       00001000 00000000 2 01 0 0 f deadbeef 0 8877665544332211 f8e7d6c5b4a39281 deadbeef
fwd_lh_neg   00001010 00000002 1 02 0 0 c 80015555 0 8877665544332211 f8e7d6c5b4a39281 ffff8001
hit_lbu      00001020 00000007 3 03 0 0 0 00000000 f 8877665544332211 f8e7d6c5b4a39281 00000088
hit_lb       00001030 00000007 0 04 0 0 0 00000000 f 8877665544332211 f8e7d6c5b4a39281 ffffff88
merge_lw     00001040 00000000 2 05 0 0 5 aabbccdd f 8877665544332211 f8e7d6c5b4a39281 44bb22dd
merge_lhu    00001050 00000004 4 06 0 0 2 00009900 1 8877665544332211 f8e7d6c5b4a39281 00009955
miss_lw      00001060 00000000 2 07 0 0 0 00000000 0 8877665544332211 f8e7d6c5b4a39281 b4a39281
miss_partial 00001070 00000004 2 08 0 0 1 12345678 4 8877665544332211 f8e7d6c5b4a39281 f877d678
miss_lh      00001080 00000002 1 09 0 0 0 00000000 0 8877665544332211 1122334455667788 00005566
miss_lb      00001090 00000005 0 0a 0 0 0 00000000 1 8877665544332211 f8e7d6c5b4a39281 ffffffd6
miss_lbu     000010a0 00000006 3 0b 0 0 0 00000000 0 8877665544332211 0f1e2d3c4b5a6978 0000001e
squash_hit   000010b0 00000000 2 0c 2 1 f 0bad0bad 0 8877665544332211 f8e7d6c5b4a39281 00000000
resolve_hit  000010c0 00000000 2 0d 1 0 0 00000000 f 8877665544332211 f8e7d6c5b4a39281 44332211
squash_miss  000010d0 00000004 1 0e 4 1 0 00000000 0 8877665544332211 f8e7d6c5b4a39281 00000000
resolve_miss 000010e0 00000008 2 0f 8 0 0 00000000 0 8877665544332211 f8e7d6c5b4a39281 b4a39281
fwd_lb_pos   000010f0 00000001 0 10 0 0 2 00007f00 0 8877665544332211 f8e7d6c5b4a39281 0000007f
